// File: hdl/mic_pkg.sv
`default_nettype none

package mic_pkg;

    // microphone word width, two's complement
    localparam int SAMPLE_W = 24;

    // filtered output width on the audio stream
    localparam int AUDIO_W = 32;

    // coefficient width in Q1.15
    localparam int COEF_W = 16;

    // filter length
    localparam int FIR_TAPS = 8;

    // accumulator holds 8 products of 40 bits with headroom to spare
    localparam int ACC_W = 48;

    // symmetric low-pass taps summing to unity gain in Q1.15
    // index 0 multiplies the newest sample
    localparam logic signed [COEF_W-1:0] FIR_COEF [FIR_TAPS] = '{
        16'sd512,
        16'sd1792,
        16'sd4608,
        16'sd9472,
        16'sd9472,
        16'sd4608,
        16'sd1792,
        16'sd512
    };

    // receiver frame tracking
    typedef enum logic [1:0] {
        RX_WAIT_WS,
        RX_DELAY,
        RX_SHIFT,
        RX_HOLD
    } rx_state_t;

    // filter sequencing
    typedef enum logic [1:0] {
        FIR_IDLE,
        FIR_ACC,
        FIR_OUT
    } fir_state_t;

    // output holding register occupancy
    typedef enum logic {
        OUT_EMPTY,
        OUT_FULL
    } out_state_t;

endpackage

`default_nettype wire

// File: hdl/i2s_clock_gen.sv
`default_nettype none

module i2s_clock_gen #(
    parameter int SCK_DIV = 4
) (
    input wire clk_in,
    input wire rst,
    output logic sck,
    output logic ws,
    output logic sck_rise
);

    // counter must hold at least one bit even for SCK_DIV of 1
    localparam int DIV_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [5:0] bit_cnt;
    logic div_wrap;

    // sck flips every SCK_DIV clk_in cycles
    assign div_wrap = (div_cnt == DIV_W'(SCK_DIV - 1));

    // bits 0..31 are the left half, 32..63 the right half
    assign ws = bit_cnt[5];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            div_cnt <= '0;
            sck <= 1'b0;
            sck_rise <= 1'b0;
            bit_cnt <= '0;
        end else begin
            sck_rise <= 1'b0;
            if (div_wrap) begin
                div_cnt <= '0;
                sck <= ~sck;
                // pulse lines up with the first cycle of sck high
                sck_rise <= ~sck;
                // falling edge closes the current bit slot
                if (sck) begin
                    bit_cnt <= bit_cnt + 6'd1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2s_rx.sv
`default_nettype none

module i2s_rx (
    input wire clk_in,
    input wire rst,
    input wire sck_rise,
    input wire ws,
    input wire sd,
    output logic signed [mic_pkg::SAMPLE_W-1:0] rx_sample,
    output logic rx_valid,
    input wire rx_ready
);
    import mic_pkg::*;

    localparam int CNT_W = $clog2(SAMPLE_W);

    rx_state_t state;
    logic ws_q;
    logic ws_fall;
    logic [CNT_W-1:0] bit_cnt;
    logic [SAMPLE_W-1:0] shift_reg;
    logic [SAMPLE_W-1:0] word_next;
    logic last_bit;

    // left half starts when ws drops
    assign ws_fall = ws_q & ~ws;

    // msb arrives first
    assign word_next = {shift_reg[SAMPLE_W-2:0], sd};
    assign last_bit = (bit_cnt == CNT_W'(SAMPLE_W - 1));

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= RX_WAIT_WS;
            // ws leaves reset low, so the first frame is seen as a fall
            ws_q <= 1'b1;
            bit_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            ws_q <= ws;
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            case (state)
                RX_WAIT_WS: begin
                    if (ws_fall) begin
                        state <= RX_DELAY;
                    end
                end
                // one-bit delay slot of the I2S format
                RX_DELAY: begin
                    if (sck_rise) begin
                        state <= RX_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                RX_SHIFT: begin
                    if (sck_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= RX_HOLD;
                            // a word still waiting keeps its place and the new one is lost
                            if (!rx_valid || rx_ready) begin
                                rx_sample <= word_next;
                                rx_valid <= 1'b1;
                            end
                        end
                    end
                end
                RX_HOLD: begin
                    // next frame may begin before the word is taken
                    if (ws_fall) begin
                        state <= RX_DELAY;
                    end else if (rx_valid && rx_ready) begin
                        state <= RX_WAIT_WS;
                    end
                end
                default: state <= RX_WAIT_WS;
            endcase
        end
    end

    // shift register takes one bit per captured sck edge
    always_ff @(posedge clk_in) begin
        if (state == RX_SHIFT && sck_rise) begin
            shift_reg <= word_next;
        end
    end

    // offered word must wait unchanged for the filter
    a_rx_hold: assert property (@(posedge clk_in) disable iff (rst)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_sample))
        else $error("rx_sample changed or rx_valid dropped before transfer");

endmodule

`default_nettype wire

// File: hdl/fir_lowpass.sv
`default_nettype none

module fir_lowpass (
    input wire clk_in,
    input wire rst,
    input wire signed [mic_pkg::SAMPLE_W-1:0] rx_sample,
    input wire rx_valid,
    output logic rx_ready,
    output logic signed [mic_pkg::AUDIO_W-1:0] fir_data,
    output logic fir_valid,
    input wire fir_ready
);
    import mic_pkg::*;

    localparam int TAP_W = $clog2(FIR_TAPS);
    localparam int PROD_W = SAMPLE_W + COEF_W;

    fir_state_t state;
    logic signed [SAMPLE_W-1:0] history [FIR_TAPS];
    logic [TAP_W-1:0] tap;
    logic last_tap;
    logic signed [ACC_W-1:0] acc;
    logic signed [PROD_W-1:0] prod;
    logic signed [ACC_W-1:0] acc_sum;
    logic signed [ACC_W-1:0] acc_scaled;

    // new sample only taken between runs
    assign rx_ready = (state == FIR_IDLE);
    assign fir_valid = (state == FIR_OUT);
    assign last_tap = (tap == TAP_W'(FIR_TAPS - 1));

    // one tap per cycle through a single multiplier
    assign prod = history[tap] * FIR_COEF[tap];
    assign acc_sum = acc + ACC_W'(prod);

    // drop the Q1.15 fraction
    assign acc_scaled = acc_sum >>> (COEF_W - 1);

    // history[0] is the newest sample
    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int k = 0; k < FIR_TAPS; k++) begin
                history[k] <= '0;
            end
        end else if (rx_valid && rx_ready) begin
            history[0] <= rx_sample;
            for (int k = 1; k < FIR_TAPS; k++) begin
                history[k] <= history[k-1];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= FIR_IDLE;
            tap <= '0;
        end else begin
            case (state)
                FIR_IDLE: begin
                    if (rx_valid) begin
                        state <= FIR_ACC;
                        tap <= '0;
                    end
                end
                // FIR_TAPS cycles of multiply-accumulate
                FIR_ACC: begin
                    tap <= tap + 1'b1;
                    if (last_tap) begin
                        state <= FIR_OUT;
                    end
                end
                // result held until mic_ctrl takes it
                FIR_OUT: begin
                    if (fir_ready) begin
                        state <= FIR_IDLE;
                    end
                end
                default: state <= FIR_IDLE;
            endcase
        end
    end

    // accumulator clears while idle and the result loads on the last tap
    always_ff @(posedge clk_in) begin
        if (state == FIR_IDLE) begin
            acc <= '0;
        end else if (state == FIR_ACC) begin
            acc <= acc_sum;
        end
        // keep the low 32 bits of the scaled sum
        if (state == FIR_ACC && last_tap) begin
            fir_data <= acc_scaled[AUDIO_W-1:0];
        end
    end

    // result appears a fixed FIR_TAPS+1 cycles after the sample is taken
    a_fir_latency: assert property (@(posedge clk_in) disable iff (rst)
        rx_valid && rx_ready |-> ##(FIR_TAPS + 1) (fir_valid && !rx_ready))
        else $error("filter output not ready FIR_TAPS+1 cycles after accept");

    a_fir_hold: assert property (@(posedge clk_in) disable iff (rst)
        fir_valid && !fir_ready |=> fir_valid && $stable(fir_data))
        else $error("fir_data changed or fir_valid dropped before transfer");

endmodule

`default_nettype wire

// File: hdl/mic_ctrl.sv
`default_nettype none

module mic_ctrl #(
    parameter int DECIM = 4
) (
    input wire clk_in,
    input wire rst,
    input wire signed [mic_pkg::AUDIO_W-1:0] fir_data,
    input wire fir_valid,
    output logic fir_ready,
    output logic signed [mic_pkg::AUDIO_W-1:0] audio_data,
    output logic audio_valid,
    input wire audio_ready,
    output logic overrun
);
    import mic_pkg::*;

    localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;

    out_state_t state;
    logic [CNT_W-1:0] decim_cnt;
    logic fir_xfer;
    logic keep;
    logic out_xfer;
    logic load;

    // filter is never stalled here
    assign fir_ready = 1'b1;
    assign fir_xfer = fir_valid && fir_ready;

    // first of every DECIM filter results survives
    assign keep = fir_xfer && (decim_cnt == '0);
    assign out_xfer = audio_valid && audio_ready;

    // register frees up in the same cycle it is read out
    assign load = keep && ((state == OUT_EMPTY) || out_xfer);
    assign audio_valid = (state == OUT_FULL);

    always_ff @(posedge clk_in) begin
        if (rst) begin
            decim_cnt <= '0;
            state <= OUT_EMPTY;
            overrun <= 1'b0;
        end else begin
            if (fir_xfer) begin
                if (decim_cnt == CNT_W'(DECIM - 1)) begin
                    decim_cnt <= '0;
                end else begin
                    decim_cnt <= decim_cnt + 1'b1;
                end
            end
            if (load) begin
                state <= OUT_FULL;
            end else if (out_xfer) begin
                state <= OUT_EMPTY;
            end
            // consumer stalled too long, kept value is gone
            if (keep && !load) begin
                overrun <= 1'b1;
            end
        end
    end

    // holding register
    always_ff @(posedge clk_in) begin
        if (load) begin
            audio_data <= fir_data;
        end
    end

    a_out_hold: assert property (@(posedge clk_in) disable iff (rst)
        audio_valid && !audio_ready |=> audio_valid && $stable(audio_data))
        else $error("audio output changed without a transfer");

endmodule

`default_nettype wire

// File: hdl/mic_frontend.sv
`default_nettype none

module mic_frontend #(
    parameter int SCK_DIV = 4,
    parameter int DECIM = 4
) (
    input wire clk_in,
    input wire rst,
    input wire mic_data,
    output logic mic_sck,
    output logic mic_ws,
    output logic signed [mic_pkg::AUDIO_W-1:0] audio_data,
    output logic audio_valid,
    input wire audio_ready,
    output logic overrun
);
    import mic_pkg::*;

    // one-cycle strobe for sampling sd in the clk_in domain
    logic sck_rise;

    // receiver to filter
    logic signed [SAMPLE_W-1:0] rx_sample;
    logic rx_valid;
    logic rx_ready;

    // filter to control
    logic signed [AUDIO_W-1:0] fir_data;
    logic fir_valid;
    logic fir_ready;

    // I2S master clocks for the microphone
    i2s_clock_gen #(
        .SCK_DIV(SCK_DIV)
    ) i_clock_gen (
        .clk_in(clk_in),
        .rst(rst),
        .sck(mic_sck),
        .ws(mic_ws),
        .sck_rise(sck_rise)
    );

    // left channel capture
    i2s_rx i_rx (
        .clk_in(clk_in),
        .rst(rst),
        .sck_rise(sck_rise),
        .ws(mic_ws),
        .sd(mic_data),
        .rx_sample(rx_sample),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready)
    );

    fir_lowpass i_fir (
        .clk_in(clk_in),
        .rst(rst),
        .rx_sample(rx_sample),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .fir_data(fir_data),
        .fir_valid(fir_valid),
        .fir_ready(fir_ready)
    );

    // decimation and output stream
    mic_ctrl #(
        .DECIM(DECIM)
    ) i_ctrl (
        .clk_in(clk_in),
        .rst(rst),
        .fir_data(fir_data),
        .fir_valid(fir_valid),
        .fir_ready(fir_ready),
        .audio_data(audio_data),
        .audio_valid(audio_valid),
        .audio_ready(audio_ready),
        .overrun(overrun)
    );

endmodule

`default_nettype wire

// File: bench/i2s_mic_model.sv
`default_nettype none

module i2s_mic_model (
    input wire clk_in,
    input wire rst,
    input wire sck,
    input wire [mic_pkg::SAMPLE_W-1:0] next_word,
    input wire next_avail,
    output logic sd = 1'b0,
    output logic took = 1'b0,
    output logic word_done = 1'b0,
    output logic done_real = 1'b0,
    output logic [mic_pkg::SAMPLE_W-1:0] done_word = '0
);
    import mic_pkg::*;

    logic sck_q = 1'b0;
    // bit slot of the frame, 0..31 left half, 32..63 right half
    logic [5:0] slot = '0;
    logic [SAMPLE_W-1:0] cur = '0;
    logic [SAMPLE_W-1:0] sreg = '0;
    logic cur_real = 1'b0;

    always @(posedge clk_in) begin
        took <= 1'b0;
        word_done <= 1'b0;
        if (rst) begin
            sck_q <= 1'b0;
            slot <= '0;
            sd <= 1'b0;
            cur <= '0;
            sreg <= '0;
            cur_real <= 1'b0;
        end else begin
            sck_q <= sck;
            // falling sck edge opens the next bit slot
            if (sck_q && !sck) begin
                slot <= slot + 6'd1;
                if (slot == 6'd0) begin
                    // slot 1 carries the msb after the one-bit delay
                    cur <= next_word;
                    sreg <= next_word;
                    cur_real <= next_avail;
                    took <= next_avail;
                    sd <= next_word[SAMPLE_W-1];
                end else if (slot <= 6'd23) begin
                    sd <= sreg[SAMPLE_W-2];
                    sreg <= sreg << 1;
                end else begin
                    // unused left slots and the whole right half
                    sd <= 1'b0;
                end
            end
            // rising edge in slot 24 is where the last bit gets captured
            if (!sck_q && sck && slot == 6'd24) begin
                word_done <= 1'b1;
                done_word <= cur;
                done_real <= cur_real;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_mic_frontend.sv
`default_nettype none

module tb_mic_frontend;
    import mic_pkg::*;

    localparam int SCK_DIV = 4;
    localparam int DECIM = 4;
    localparam int CLK_PERIOD = 8;
    localparam int FRAME_CYCLES = 64 * 2 * SCK_DIV;
    // words pushed by all phases plus margin for drains and the reset
    localparam int TOTAL_FRAMES = 100;
    localparam logic [31:0] SEED = 32'h77427449;

    logic clk;
    logic rst;
    logic mic_data;
    logic mic_sck;
    logic mic_ws;
    logic signed [AUDIO_W-1:0] audio_data;
    logic audio_valid;
    logic audio_ready;
    logic overrun;

    // microphone model hookup
    logic [SAMPLE_W-1:0] next_word;
    logic next_avail;
    logic took;
    logic word_done;
    logic done_real;
    logic [SAMPLE_W-1:0] done_word;

    // words waiting to be sent, oldest first
    logic [SAMPLE_W-1:0] word_q [$];
    logic [31:0] seed;
    int cyc;
    int real_pending;

    // reference filter and decimator
    longint hist [FIR_TAPS];
    int dcnt;
    logic [31:0] pend_val [$];
    int pend_cyc [$];

    // reference output register
    logic m_full;
    logic [31:0] m_data;
    logic m_over;

    // clock shape tracking
    logic sck_q;
    logic ws_q;
    logic rise_seen;
    int last_rise;
    int rises_since_ws;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mic_frontend #(
        .SCK_DIV(SCK_DIV),
        .DECIM(DECIM)
    ) i_mic_frontend (
        .clk_in(clk),
        .rst(rst),
        .mic_data(mic_data),
        .mic_sck(mic_sck),
        .mic_ws(mic_ws),
        .audio_data(audio_data),
        .audio_valid(audio_valid),
        .audio_ready(audio_ready),
        .overrun(overrun)
    );

    i2s_mic_model mic (
        .clk_in(clk),
        .rst(rst),
        .sck(mic_sck),
        .next_word(next_word),
        .next_avail(next_avail),
        .sd(mic_data),
        .took(took),
        .word_done(word_done),
        .done_real(done_real),
        .done_word(done_word)
    );

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got)
        else report_fail($sformatf("error at %0t: %s expected %h, got %h", $time, name, exp, got));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one captured word through the filter rule and the keep-one-of-DECIM rule
    task automatic ref_word(input logic [SAMPLE_W-1:0] w);
        longint acc;
        longint scaled;
        acc = 0;
        for (int k = FIR_TAPS - 1; k > 0; k--) begin
            hist[k] = hist[k-1];
        end
        hist[0] = longint'($signed(w));
        for (int k = 0; k < FIR_TAPS; k++) begin
            acc = acc + hist[k] * longint'(FIR_COEF[k]);
        end
        scaled = acc >>> 15;
        if (dcnt == 0) begin
            pend_val.push_back(scaled[31:0]);
            // valid shows 11 cycles after the last bit, load is one edge earlier
            pend_cyc.push_back(cyc + 9);
        end
        dcnt = (dcnt + 1) % DECIM;
    endtask

    always @(posedge clk) begin
        logic xfer;
        if (rst) begin
            for (int k = 0; k < FIR_TAPS; k++) begin
                hist[k] = 0;
            end
            dcnt = 0;
            pend_val.delete();
            pend_cyc.delete();
            m_full = 1'b0;
            m_over = 1'b0;
            real_pending = 0;
            rise_seen = 1'b0;
            rises_since_ws = 0;
            sck_q = 1'b0;
            ws_q = 1'b0;
        end else begin
            // sck period and half-frame length
            if (mic_sck && !sck_q) begin
                if (rise_seen) begin
                    check_value("mic_sck period", 2 * SCK_DIV, cyc - last_rise);
                end
                last_rise = cyc;
                rise_seen = 1'b1;
                rises_since_ws = rises_since_ws + 1;
            end
            if (mic_ws != ws_q) begin
                check_value("mic_ws half-frame sck count", 32, rises_since_ws);
                rises_since_ws = 0;
            end
            sck_q = mic_sck;
            ws_q = mic_ws;
            // stream outputs against the reference register
            check_value("audio_valid", 32'(m_full), 32'(audio_valid));
            if (m_full) begin
                check_value("audio_data", m_data, audio_data);
            end
            check_value("overrun", 32'(m_over), 32'(overrun));
            xfer = m_full && audio_ready;
            if (pend_cyc.size() > 0 && pend_cyc[0] == cyc) begin
                void'(pend_cyc.pop_front());
                if (!m_full || xfer) begin
                    m_data = pend_val.pop_front();
                    m_full = 1'b1;
                end else begin
                    // kept value lost behind a stalled consumer
                    void'(pend_val.pop_front());
                    m_over = 1'b1;
                end
            end else if (xfer) begin
                m_full = 1'b0;
            end
            if (word_done) begin
                ref_word(done_word);
                if (done_real) begin
                    real_pending = real_pending - 1;
                end
            end
            if (took) begin
                if (word_q.size() > 0) begin
                    void'(word_q.pop_front());
                end
                real_pending = real_pending + 1;
            end
        end
        next_word <= (word_q.size() > 0) ? word_q[0] : '0;
        next_avail <= (word_q.size() > 0);
        cyc = cyc + 1;
    end

    task automatic push_random(input int n);
        for (int i = 0; i < n; i++) begin
            seed = lcg_next(seed);
            word_q.push_back(seed[31:8]);
        end
    endtask

    // all queued words captured and every kept value delivered
    task automatic drain();
        while (word_q.size() != 0 || real_pending != 0 || pend_cyc.size() != 0
               || (m_full && audio_ready)) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        audio_ready = 1'b1;
        next_word = '0;
        next_avail = 1'b0;
        seed = SEED;
        cyc = 0;
        real_pending = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // impulse response
        @(posedge clk);
        word_q.push_back(24'h100000);
        for (int i = 0; i < 15; i++) begin
            word_q.push_back('0);
        end
        drain();
        // free-running random stream
        push_random(24);
        drain();
        // consumer stalls across several frames
        @(posedge clk);
        audio_ready <= 1'b0;
        push_random(12);
        drain();
        assert (overrun)
        else report_fail("overrun stayed low although kept values were lost during the stall");
        @(posedge clk);
        audio_ready <= 1'b1;
        push_random(8);
        drain();
        // reset in the middle of a stream
        push_random(12);
        while (word_q.size() > 6) begin
            @(posedge clk);
        end
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        word_q.delete();
        rst <= 1'b0;
        push_random(8);
        drain();
        $display("No errors");
        $finish;
    end

    // watchdog sized from the frame budget
    initial begin
        #(2 * TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD);
        report_fail("timeout: the test sequence did not finish in the allowed time");
    end

endmodule

`default_nettype wire

// File: sim.f
hdl/mic_pkg.sv
hdl/i2s_clock_gen.sv
hdl/i2s_rx.sv
hdl/fir_lowpass.sv
hdl/mic_ctrl.sv
hdl/mic_frontend.sv
bench/i2s_mic_model.sv
bench/tb_mic_frontend.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_mic_frontend
FILELIST  := sim.f
BUILD     := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
